// ==== lossless_pkg.sv ====
// Shared widths, header words, command kinds and tables; the zigzag table assumes 8x8 blocks
`default_nettype none

package lossless_pkg;

	localparam int WINDOW_W     = 13;
	localparam int BLOCK_COEFFS = 64;
	localparam int BUF_W        = 48;

	typedef logic [17:0]         sram_addr_t;
	typedef logic [15:0]         sram_word_t;
	typedef logic signed [8:0]   coeff_t;
	typedef logic [5:0]          coeff_idx_t;
	typedef logic [5:0]          dp_addr_t;
	typedef logic [31:0]         dp_data_t;
	typedef logic [2:0]          shift_t;
	typedef logic [3:0]          run_t;
	typedef logic [WINDOW_W-1:0] window_t;
	typedef logic [3:0]          code_len_t;

	typedef enum logic [1:0] {
		CMD_COEFF,
		CMD_ZEROS,
		CMD_EOB
	} cmd_kind_e;

	localparam sram_addr_t STREAM_BASE = 18'd76800;
	localparam sram_word_t HDR_WORD0   = 16'hDEAD;
	localparam sram_word_t HDR_WORD1   = 16'hBEEF;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Zigzag index to raster address
	localparam dp_addr_t ZIGZAG_TABLE [BLOCK_COEFFS] = '{
		6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
		6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
		6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
		6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
		6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
		6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
		6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
		6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shift per anti-diagonal, one table per quantiser
	localparam shift_t SHIFT_TABLE_Q0 [15] = '{
		3'd3, 3'd2, 3'd3, 3'd3, 3'd4, 3'd4, 3'd5, 3'd5,
		3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6
	};

	localparam shift_t SHIFT_TABLE_Q1 [15] = '{
		3'd3, 3'd1, 3'd1, 3'd1, 3'd2, 3'd2, 3'd3, 3'd3,
		3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6
	};

endpackage

`default_nettype wire

// ==== lossless_ifs.sv ====
// Internal links of the decoder; coeff_if has no ready since the writer takes every cycle
`timescale 1ns/1ps
`default_nettype none

interface bit_window_if;
	import lossless_pkg::*;

	window_t   window;
	logic      valid;
	logic      take;
	code_len_t len;

	modport supplier (output window, valid, input take, len);
	modport consumer (input window, valid, output take, len);
endinterface

interface cmd_if;
	import lossless_pkg::*;

	logic      valid;
	cmd_kind_e kind;
	coeff_t    value;
	run_t      run;
	logic      ready;

	modport producer (output valid, kind, value, run, input ready);
	modport consumer (input valid, kind, value, run, output ready);
endinterface

interface coeff_if;
	import lossless_pkg::*;

	logic       valid;
	coeff_idx_t index;
	coeff_t     value;
	logic       last;

	modport source (output valid, index, value, last);
	modport sink (input valid, index, value, last);
endinterface

`default_nettype wire

// ==== bitstream_fetch.sv ====
// Single Wishbone classic read in flight; header read once on first start, bad header is sticky
`timescale 1ns/1ps
`default_nettype none

module bitstream_fetch (
	input  logic                    Clock_50,
	input  logic                    Resetn,
	input  logic                    start,
	output logic                    sram_cyc,
	output logic                    sram_stb,
	output lossless_pkg::sram_addr_t sram_adr,
	input  lossless_pkg::sram_word_t sram_dat_r,
	input  logic                    sram_ack,
	output logic                    q_sel,
	output logic                    header_error,
	bit_window_if.supplier          win
);
	import lossless_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_HEADER,
		S_STREAM,
		S_ERROR
	} fetch_state_e;

	fetch_state_e     state;
	logic             req;
	logic [1:0]       hdr_cnt;
	logic             hdr_ok;
	logic [BUF_W-1:0] bit_buf;
	logic [5:0]       bit_cnt;
	logic             take_fire;
	logic             fill;
	logic [BUF_W-1:0] shifted;
	logic [5:0]       cnt_after;
	logic [BUF_W-1:0] buf_next;
	logic [5:0]       cnt_next;

	assign sram_cyc   = req;
	assign sram_stb   = req;
	assign win.window = bit_buf[BUF_W-1 -: WINDOW_W];
	assign win.valid  = (bit_cnt >= 6'(WINDOW_W));

	// Consume and refill can land in the same cycle
	always_comb begin
		take_fire = win.valid & win.take;
		fill      = (state == S_STREAM) & req & sram_ack;
		shifted   = take_fire ? (bit_buf << win.len) : bit_buf;
		cnt_after = take_fire ? (bit_cnt - {2'b00, win.len}) : bit_cnt;
		buf_next  = shifted;
		cnt_next  = cnt_after;
		if (fill) begin
			// New word lands right below the valid bits
			buf_next = shifted | ({sram_dat_r, {(BUF_W-$bits(sram_word_t)){1'b0}}} >> cnt_after);
			cnt_next = cnt_after + 6'd16;
		end
	end

	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (~Resetn) begin
			state        <= S_IDLE;
			req          <= 1'b0;
			sram_adr     <= STREAM_BASE;
			hdr_cnt      <= 2'd0;
			hdr_ok       <= 1'b0;
			q_sel        <= 1'b0;
			header_error <= 1'b0;
			bit_buf      <= '0;
			bit_cnt      <= 6'd0;
		end else begin
			case (state)
			S_IDLE: begin
				if (start) begin
					state <= S_HEADER;
				end
			end
			S_HEADER: begin
				if (!req) begin
					req <= 1'b1;
				end else if (sram_ack) begin
					req      <= 1'b0;
					sram_adr <= sram_adr + 1'b1;
					hdr_cnt  <= hdr_cnt + 2'd1;
					case (hdr_cnt)
					2'd0: hdr_ok <= (sram_dat_r == HDR_WORD0);
					2'd1: hdr_ok <= hdr_ok & (sram_dat_r == HDR_WORD1);
					default: begin
						if (hdr_ok) begin
							q_sel <= sram_dat_r[15];
							state <= S_STREAM;
						end else begin
							header_error <= 1'b1;
							state        <= S_ERROR;
						end
					end
					endcase
				end
			end
			S_STREAM: begin
				// Fetch ahead while a whole word still fits
				if (!req && bit_cnt <= 6'(BUF_W - 16)) begin
					req <= 1'b1;
				end else if (fill) begin
					req      <= 1'b0;
					sram_adr <= sram_adr + 1'b1;
				end
				bit_buf <= buf_next;
				bit_cnt <= cnt_next;
			end
			default: begin
				state <= S_ERROR;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== code_decoder.sv ====
// One code per transfer, combinational from the window; pairs go out as two commands
`timescale 1ns/1ps
`default_nettype none

module code_decoder (
	input  logic           Clock_50,
	input  logic           Resetn,
	bit_window_if.consumer win,
	cmd_if.producer        cmd
);
	import lossless_pkg::*;

	window_t w;
	logic    pair_due;
	logic    fire;

	assign w = win.window;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Code table
	always_comb begin
		cmd.valid = win.valid;
		cmd.kind  = CMD_COEFF;
		cmd.value = '0;
		cmd.run   = 4'd1;
		win.len   = 4'd5;
		if (pair_due) begin
			// Second value of a pair
			cmd.value = {{6{w[12]}}, w[12:10]};
			win.len   = 4'd3;
		end else begin
			case (w[12:11])
			2'b00, 2'b01: begin
				cmd.value = {{6{w[10]}}, w[10:8]};
			end
			2'b11: begin
				cmd.kind = CMD_ZEROS;
				cmd.run  = (w[10:8] == 3'd0) ? 4'd8 : {1'b0, w[10:8]};
			end
			default: begin
				if (!w[10]) begin
					cmd.value = {{3{w[9]}}, w[9:4]};
					win.len   = 4'd9;
				end else if (!w[9]) begin
					cmd.kind = CMD_EOB;
					win.len  = 4'd4;
				end else begin
					cmd.value = w[8:0];
					win.len   = 4'd13;
				end
			end
			endcase
		end
	end

	assign fire     = cmd.valid & cmd.ready;
	assign win.take = fire;

	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (~Resetn) begin
			pair_due <= 1'b0;
		end else if (fire) begin
			pair_due <= !pair_due && (w[12:11] == 2'b00);
		end
	end

endmodule

`default_nettype wire

// ==== run_expander.sv ====
// One coefficient per cycle while a block is active; runs are cut at the block end
`timescale 1ns/1ps
`default_nettype none

module run_expander (
	input  logic     Clock_50,
	input  logic     Resetn,
	input  logic     start,
	cmd_if.consumer  cmd,
	coeff_if.source  coeff
);
	import lossless_pkg::*;

	logic       active;
	coeff_idx_t index;
	run_t       zero_left;
	run_t       remaining;
	logic       at_end;
	logic       cmd_done;

	always_comb begin
		// zero_left of zero means no run in progress
		remaining = (zero_left != 4'd0) ? zero_left : cmd.run;
		at_end    = (index == coeff_idx_t'(BLOCK_COEFFS - 1));
		case (cmd.kind)
		CMD_COEFF: cmd_done = 1'b1;
		CMD_ZEROS: cmd_done = (remaining == 4'd1) || at_end;
		default:   cmd_done = at_end;
		endcase
		cmd.ready   = active & cmd_done;
		coeff.valid = active & cmd.valid;
		coeff.index = index;
		coeff.value = (cmd.kind == CMD_COEFF) ? cmd.value : '0;
		coeff.last  = at_end;
	end

	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (~Resetn) begin
			active    <= 1'b0;
			index     <= '0;
			zero_left <= 4'd0;
		end else if (!active) begin
			if (start) begin
				active <= 1'b1;
			end
		end else if (coeff.valid) begin
			// Index wraps to 0 after the last coefficient
			index <= index + 1'b1;
			if (at_end) begin
				active <= 1'b0;
			end
			if (cmd.kind == CMD_ZEROS) begin
				zero_left <= cmd_done ? 4'd0 : (remaining - 4'd1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== coeff_writer.sv ====
// Write lands one cycle after the coefficient, finish one cycle after the last write
`timescale 1ns/1ps
`default_nettype none

module coeff_writer (
	input  logic                   Clock_50,
	input  logic                   Resetn,
	input  logic                   q_sel,
	coeff_if.sink                  coeff,
	output logic                   dp_we,
	output lossless_pkg::dp_addr_t dp_adr,
	output lossless_pkg::dp_data_t dp_dat,
	output logic                   finish
);
	import lossless_pkg::*;

	dp_addr_t   raster;
	logic [3:0] diag;
	shift_t     shift;
	logic       last_q;

	always_comb begin
		raster = ZIGZAG_TABLE[coeff.index];
		// Row plus column
		diag   = {1'b0, raster[5:3]} + {1'b0, raster[2:0]};
		shift  = q_sel ? SHIFT_TABLE_Q1[diag] : SHIFT_TABLE_Q0[diag];
	end

	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (~Resetn) begin
			dp_we  <= 1'b0;
			last_q <= 1'b0;
			finish <= 1'b0;
		end else begin
			dp_we  <= coeff.valid;
			last_q <= coeff.valid & coeff.last;
			finish <= last_q;
		end
	end

	always_ff @(posedge Clock_50) begin
		dp_adr <= raster;
		dp_dat <= dp_data_t'({{23{coeff.value[8]}}, coeff.value}) << shift;
	end

endmodule

`default_nettype wire

// ==== lossless_decoder_top.sv ====
// Decodes one block per start; start is ignored while a block is active, no write back-pressure
`timescale 1ns/1ps
`default_nettype none

module lossless_decoder_top (
	input  logic                     Clock_50,
	input  logic                     Resetn,
	input  logic                     start,
	output logic                     sram_cyc,
	output logic                     sram_stb,
	output lossless_pkg::sram_addr_t sram_adr,
	input  lossless_pkg::sram_word_t sram_dat_r,
	input  logic                     sram_ack,
	output logic                     dp_we,
	output lossless_pkg::dp_addr_t   dp_adr,
	output lossless_pkg::dp_data_t   dp_dat,
	output logic                     finish,
	output logic                     header_error
);

	logic q_sel;

	bit_window_if win_link ();
	cmd_if        cmd_link ();
	coeff_if      coeff_link ();

	bitstream_fetch u_fetch (
		.Clock_50     (Clock_50),
		.Resetn       (Resetn),
		.start        (start),
		.sram_cyc     (sram_cyc),
		.sram_stb     (sram_stb),
		.sram_adr     (sram_adr),
		.sram_dat_r   (sram_dat_r),
		.sram_ack     (sram_ack),
		.q_sel        (q_sel),
		.header_error (header_error),
		.win          (win_link.supplier)
	);

	code_decoder u_decoder (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.win      (win_link.consumer),
		.cmd      (cmd_link.producer)
	);

	run_expander u_expander (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.start    (start),
		.cmd      (cmd_link.consumer),
		.coeff    (coeff_link.source)
	);

	coeff_writer u_writer (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.q_sel    (q_sel),
		.coeff    (coeff_link.sink),
		.dp_we    (dp_we),
		.dp_adr   (dp_adr),
		.dp_dat   (dp_dat),
		.finish   (finish)
	);

endmodule

`default_nettype wire

// ==== tb_lossless_decoder.sv ====
// Two good streams then a bad header; the stream model covers 512 words from STREAM_BASE
`timescale 1ns/1ps
`default_nettype none

module tb_lossless_decoder;
	import lossless_pkg::*;

	localparam int MEM_WORDS     = 512;
	localparam int BLOCK_TIMEOUT = 3000;
	localparam int HDR_TIMEOUT   = 200;

	logic       Clock_50;
	logic       Resetn;
	logic       start;
	logic       sram_cyc;
	logic       sram_stb;
	sram_addr_t sram_adr;
	sram_word_t sram_dat_r;
	logic       sram_ack;
	logic       dp_we;
	dp_addr_t   dp_adr;
	dp_data_t   dp_dat;
	logic       finish;
	logic       header_error;

	integer     seed;
	sram_word_t mem [MEM_WORDS];
	bit         stream_bits [$];
	dp_addr_t   exp_adr [$];
	dp_data_t   exp_dat [$];
	logic       busy;
	int         waits;
	sram_addr_t req_adr;

	lossless_decoder_top DUT (.*);

	initial begin
		Clock_50 = 1'b0;
		forever #10 Clock_50 = ~Clock_50;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers

	function automatic int pick(int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "Stopped at first failure");
	endtask

	task automatic check_flag(logic got, logic want, string name);
		if (got !== want) begin
			report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, want));
		end
	endtask

	task automatic check_adr(sram_addr_t got, sram_addr_t want);
		if (got !== want) begin
			report_failure($sformatf("[ERROR] sram_adr got %h expected %h", got, want));
		end
	endtask

	task automatic check_write(
		dp_addr_t got_adr,
		dp_data_t got_dat,
		dp_addr_t want_adr,
		dp_data_t want_dat
	);
		if (got_adr !== want_adr) begin
			report_failure($sformatf("[ERROR] dp_adr got %h expected %h", got_adr, want_adr));
		end
		if (got_dat !== want_dat) begin
			report_failure($sformatf("[ERROR] dp_dat got %h expected %h", got_dat, want_dat));
		end
	endtask

	// Outside the loaded range the word follows the address
	function automatic sram_word_t read_word(sram_addr_t adr);
		int off;
		off = int'(adr) - int'(STREAM_BASE);
		if (off >= 0 && off < MEM_WORDS) begin
			return mem[off];
		end else begin
			return sram_word_t'(adr ^ (adr >> 3));
		end
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Encoder and reference model

	function automatic void put_bits(int value, int n);
		int i;
		for (i = n - 1; i >= 0; i--) begin
			stream_bits.push_back(value[i]);
		end
	endfunction

	function automatic void expect_coeff(int idx, int value, logic q);
		dp_addr_t raster;
		int       diag;
		shift_t   sh;
		raster = ZIGZAG_TABLE[idx];
		diag   = raster / 8 + raster % 8;
		sh     = q ? SHIFT_TABLE_Q1[diag] : SHIFT_TABLE_Q0[diag];
		exp_adr.push_back(raster);
		exp_dat.push_back(dp_data_t'(value) << sh);
	endfunction

	function automatic void encode_block(int blk, logic q);
		int   idx;
		int   step;
		int   kind;
		int   v;
		int   v2;
		int   n;
		logic forced;
		idx  = 0;
		step = 0;
		while (idx < BLOCK_COEFFS) begin
			// First block walks through every code kind once
			forced = (blk == 0) && (step < 6);
			kind   = forced ? step : pick(6);
			step++;
			if (kind == 1 && idx > BLOCK_COEFFS - 2) begin
				kind = 0;
			end
			case (kind)
			0: begin
				v = pick(8) - 4;
				put_bits(1, 2);
				put_bits(v, 3);
				expect_coeff(idx, v, q);
				idx++;
			end
			1: begin
				v  = pick(8) - 4;
				v2 = pick(8) - 4;
				put_bits(0, 2);
				put_bits(v, 3);
				put_bits(v2, 3);
				expect_coeff(idx, v, q);
				expect_coeff(idx + 1, v2, q);
				idx += 2;
			end
			2: begin
				v = pick(64) - 32;
				put_bits(4, 3);
				put_bits(v, 6);
				expect_coeff(idx, v, q);
				idx++;
			end
			3: begin
				v = pick(512) - 256;
				put_bits(11, 4);
				put_bits(v, 9);
				expect_coeff(idx, v, q);
				idx++;
			end
			4: begin
				n = forced ? 8 : pick(8) + 1;
				if (idx + n > BLOCK_COEFFS) begin
					n = BLOCK_COEFFS - idx;
				end
				put_bits(3, 2);
				put_bits(n % 8, 3);
				repeat (n) begin
					expect_coeff(idx, 0, q);
					idx++;
				end
			end
			default: begin
				put_bits(10, 4);
				while (idx < BLOCK_COEFFS) begin
					expect_coeff(idx, 0, q);
					idx++;
				end
			end
			endcase
		end
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wishbone slave with 0 to 3 wait states
	initial begin
		sram_ack   = 1'b0;
		sram_dat_r = '0;
		busy       = 1'b0;
		waits      = 0;
		req_adr    = '0;
		forever begin
			@(posedge Clock_50);
			#1;
			if (!Resetn) begin
				sram_ack = 1'b0;
				busy     = 1'b0;
			end else if (sram_ack) begin
				// Master drops stb right after the acknowledge
				sram_ack = 1'b0;
				busy     = 1'b0;
				check_flag(sram_stb, 1'b0, "sram_stb");
			end else if (sram_cyc && sram_stb) begin
				if (!busy) begin
					busy    = 1'b1;
					waits   = pick(4);
					req_adr = sram_adr;
				end
				check_adr(sram_adr, req_adr);
				if (waits == 0) begin
					sram_ack   = 1'b1;
					sram_dat_r = read_word(sram_adr);
				end else begin
					waits--;
				end
			end else if (busy) begin
				report_failure("Wishbone read was dropped before its acknowledge");
			end
		end
	end

	// Reset held while the next stream is loaded
	task automatic restart(logic q, int nblocks, logic bad);
		int         w;
		int         b;
		sram_word_t word;
		@(posedge Clock_50);
		#1;
		Resetn = 1'b0;
		start  = 1'b0;
		stream_bits.delete();
		exp_adr.delete();
		exp_dat.delete();
		for (b = 0; b < nblocks; b++) begin
			encode_block(b, q);
		end
		while (stream_bits.size() % 16 != 0) begin
			stream_bits.push_back(bit'(pick(2)));
		end
		mem[0] = HDR_WORD0;
		mem[1] = bad ? (HDR_WORD1 ^ sram_word_t'(1 << pick(16))) : HDR_WORD1;
		mem[2] = {q, 15'(pick(32768))};
		for (w = 3; w < MEM_WORDS; w++) begin
			if (w - 3 < stream_bits.size() / 16) begin
				for (b = 0; b < 16; b++) begin
					word[15 - b] = stream_bits[(w - 3) * 16 + b];
				end
			end else begin
				word = sram_word_t'(pick(65536));
			end
			mem[w] = word;
		end
		repeat (8) @(posedge Clock_50);
		#1;
		Resetn = 1'b1;
		check_flag(sram_cyc, 1'b0, "sram_cyc");
		check_flag(sram_stb, 1'b0, "sram_stb");
		check_flag(dp_we, 1'b0, "dp_we");
		check_flag(header_error, 1'b0, "header_error");
		check_flag(finish, 1'b0, "finish");
	endtask

	task automatic run_block(int blk);
		int   writes;
		int   cycles;
		logic done;
		writes = 0;
		cycles = 0;
		done   = 1'b0;
		start  = 1'b1;
		while (!done) begin
			@(posedge Clock_50);
			#1;
			start = 1'b0;
			cycles++;
			if (finish) begin
				if (writes != BLOCK_COEFFS) begin
					report_failure($sformatf("Block %0d finished after %0d writes instead of 64",
						blk, writes));
				end
				done = 1'b1;
			end else if (writes == BLOCK_COEFFS) begin
				report_failure($sformatf("No finish pulse after the last write of block %0d", blk));
			end
			if (dp_we) begin
				if (exp_adr.size() == 0 || writes == BLOCK_COEFFS) begin
					report_failure($sformatf("Unexpected RAM write after block %0d ended", blk));
				end
				check_write(dp_adr, dp_dat, exp_adr.pop_front(), exp_dat.pop_front());
				writes++;
			end
			if (!done && cycles > BLOCK_TIMEOUT) begin
				report_failure($sformatf("Timeout waiting for finish of block %0d", blk));
			end
		end
	endtask

	task automatic check_idle(int n, logic err);
		repeat (n) begin
			@(posedge Clock_50);
			#1;
			check_flag(dp_we, 1'b0, "dp_we");
			check_flag(finish, 1'b0, "finish");
			check_flag(header_error, err, "header_error");
		end
	endtask

	task automatic wait_header_error();
		int cycles;
		cycles = 0;
		start  = 1'b1;
		while (!header_error) begin
			@(posedge Clock_50);
			#1;
			start = 1'b0;
			cycles++;
			check_flag(dp_we, 1'b0, "dp_we");
			check_flag(finish, 1'b0, "finish");
			if (!header_error && cycles > HDR_TIMEOUT) begin
				report_failure("Timeout waiting for header_error after a bad header");
			end
		end
		start = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	initial begin
		int blk;
		seed   = 32'hccf160d7;
		Resetn = 1'b0;
		start  = 1'b0;

		restart(1'b0, 6, 1'b0);
		for (blk = 0; blk < 6; blk++) begin
			run_block(blk);
		end
		if (exp_adr.size() != 0) begin
			report_failure("Expected writes left over after the Q0 stream");
		end
		check_idle(20, 1'b0);

		restart(1'b1, 4, 1'b0);
		for (blk = 0; blk < 4; blk++) begin
			run_block(blk);
		end
		if (exp_adr.size() != 0) begin
			report_failure("Expected writes left over after the Q1 stream");
		end
		check_idle(20, 1'b0);

		// Word 1 corrupted so the decoder must stay silent
		restart(1'b0, 0, 1'b1);
		wait_header_error();
		check_idle(200, 1'b1);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
lossless_pkg.sv
lossless_ifs.sv
bitstream_fetch.sv
code_decoder.sv
run_expander.sv
coeff_writer.sv
lossless_decoder_top.sv
tb_lossless_decoder.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_lossless_decoder -f tb.f
	./obj_dir/Vtb_lossless_decoder | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
